// File: Makefile
# Verilator build and run for the four-requester arbiter.
# Usage: make sim, make clean. Variables may be overridden, e.g.
# make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_arb4_top
FILELIST  ?= arb4.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= TEST RESULT: FAIL
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: arb4.f
source/arb_pkg.sv
source/pn_seq_gen.sv
source/arb_mode_decode.sv
source/grant_select.sv
source/grant_register.sv
source/arb4_top.sv
dv/tb_arb4_top.sv

// File: dv/arb_trace.txt
# tag req arb_type gnt  (req, arb_type and gnt in hex, one cycle per line)
# gnt is the expected grant one cycle after req and arb_type are driven
rand f 5 2
rand f 5 8
rand f 5 8
rand f 5 4
rand f 5 2
rand f 5 4
rand f 5 1
rand 5 5 1
rand 6 5 2
rand 9 5 8
rand b 5 1
rand c 5 4
rand a 5 2
rand 8 5 8
fix_p0 f 0 1
fix_p0 e 0 2
fix_p0 c 0 4
fix_p0 8 0 8
fix_p0 a 0 2
fix_p0 0 0 0
fix_p1 f 1 2
fix_p1 d 1 1
fix_p1 2 1 2
fix_p1 c 1 4
fix_p1 6 1 2
fix_p1 9 1 1
fix_p2 f 2 4
fix_p2 b 2 1
fix_p2 a 2 2
fix_p2 4 2 4
fix_p2 8 2 8
fix_p2 7 2 4
fix_p3 f 3 8
fix_p3 7 3 1
fix_p3 6 3 2
fix_p3 9 3 8
fix_p3 4 3 4
fix_p3 e 3 8
rr_all f 4 1
rr_all f 4 2
rr_all f 4 4
rr_all f 4 8
rr_all f 4 1
rr_sparse a 4 2
rr_sparse a 4 8
rr_sparse 0 4 0
rr_sparse a 4 2
rr_sparse 5 4 4
rr_sparse 3 4 1
rr_sparse 0 4 0
rr_sparse 1 4 1
rr_sparse 9 4 8
illegal f 6 0
illegal f 7 0
illegal 5 6 0
illegal 2 7 0
illegal f 4 1
illegal f 4 2
idle_switch 0 0 0
idle_switch 0 5 0
idle_switch 0 4 0
idle_switch f 4 4
idle_switch f 3 8
idle_switch f 4 1
idle_switch 3 1 2
idle_switch f 7 0
idle_switch 6 4 4
idle_switch 0 0 0

// File: dv/tb_arb4_top.sv
// ----------------------------------------------------------------------
// Testbench for arb4_top that replays the grant trace cycle by cycle and
// checks each grant one cycle after its request and mode are driven.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_arb4_top import arb_pkg::*; ();

  localparam int    TAG_W         = 8 * 16;
  localparam int    RESET_CYCLES  = 5;
  localparam int    RESET_TIMEOUT = 20;  // Cycles to wait for rst_n
  localparam int    TRACE_TIMEOUT = 500; // Read loop cycles
  localparam string TRACE_FILE    = "dv/arb_trace.txt";

  localparam logic [TAG_W-1:0] COMMENT_TAG = "#";

  logic               clk = 1'b0;
  logic               rst_n;
  logic [NUM_REQ-1:0] req;
  logic [MODE_W-1:0]  arb_type;
  logic [NUM_REQ-1:0] gnt;

  logic [TAG_W-1:0] cur_tag;
  int               test_checks;
  int               test_errs;
  int               tests_passed;
  int               tests_failed;
  int               total_errs;
  bit               aborted;

  arb4_top arb4_top_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .arb_type (arb_type),
    .gnt      (gnt)
  );

  initial begin
    forever #20 clk = ~clk; // 40 ns period
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

  task automatic check_gnt(input logic [NUM_REQ-1:0] actual,
                           input logic [NUM_REQ-1:0] expected);
    test_checks++;
    if (actual !== expected) begin
      test_errs++;
      total_errs++;
      $display("Error at %0t: gnt = %h, expected %h in test %0s",
               $time, actual, expected, cur_tag);
    end
  endtask

  // Report the running test and clear its counters
  task automatic finish_test();
    if (cur_tag != '0) begin
      if (test_errs == 0) begin
        tests_passed++;
        $display("Test %0s finished: %0d checks ok", cur_tag, test_checks);
      end else begin
        tests_failed++;
        $display("Test %0s finished: %0d of %0d checks wrong",
                 cur_tag, test_errs, test_checks);
      end
    end
    test_checks = 0;
    test_errs   = 0;
  endtask

  task automatic start_test(input logic [TAG_W-1:0] tag);
    if (tag != cur_tag) begin
      finish_test();
      cur_tag = tag;
    end
  endtask

  initial begin
    int                 fd;
    int                 n;
    int                 waited;
    int                 cycles;
    bit                 have_pend;
    bit                 at_end;
    logic [TAG_W-1:0]   tag;
    logic [TAG_W-1:0]   pend_tag;
    logic [NUM_REQ-1:0] req_v;
    logic [MODE_W-1:0]  mode_v;
    logic [NUM_REQ-1:0] exp_v;
    logic [NUM_REQ-1:0] pend_exp;
    logic [8*128-1:0]   rest;

    $timeformat(-9, 0, " ns", 0);
    req          = '0;
    arb_type     = MODE_P0;
    cur_tag      = '0;
    test_checks  = 0;
    test_errs    = 0;
    tests_passed = 0;
    tests_failed = 0;
    total_errs   = 0;
    aborted      = 1'b0;
    fd           = 0;
    have_pend    = 1'b0;

    // Grant stays low while reset is held
    start_test("reset");
    waited = 0;
    while (rst_n !== 1'b1 && !aborted) begin
      @(negedge clk);
      check_gnt(gnt, '0);
      waited++;
      if (waited > RESET_TIMEOUT) begin
        $display("Reset was not released within %0d cycles", RESET_TIMEOUT);
        aborted = 1'b1;
      end
    end

    if (!aborted) begin
      fd = $fopen(TRACE_FILE, "r");
      if (fd == 0) begin
        $display("Could not open trace file %s", TRACE_FILE);
        aborted = 1'b1;
      end
    end

    // Line k is driven while the grant of line k-1 is checked
    at_end = aborted;
    cycles = 0;
    while (!at_end) begin
      n = $fscanf(fd, "%s", tag);
      cycles++;
      if (n != 1) begin
        at_end = 1'b1;
      end else if (tag == COMMENT_TAG) begin
        n = $fgets(rest, fd);
      end else begin
        n = $fscanf(fd, "%h %h %h", req_v, mode_v, exp_v);
        if (n != 3) begin
          $display("Trace line of test %0s could not be read", tag);
          aborted = 1'b1;
          at_end  = 1'b1;
        end else begin
          @(posedge clk);
          req      <= req_v;
          arb_type <= mode_v;
          @(negedge clk);
          if (have_pend) begin
            start_test(pend_tag);
            check_gnt(gnt, pend_exp);
          end
          have_pend = 1'b1;
          pend_tag  = tag;
          pend_exp  = exp_v;
        end
      end
      if (!at_end && cycles > TRACE_TIMEOUT) begin
        $display("Trace read loop did not finish within %0d cycles", TRACE_TIMEOUT);
        aborted = 1'b1;
        at_end  = 1'b1;
      end
    end

    if (!aborted && !have_pend) begin
      $display("Trace file held no test lines");
      aborted = 1'b1;
    end

    // One idle cycle to see the last traced grant
    if (have_pend && !aborted) begin
      @(posedge clk);
      req      <= '0;
      arb_type <= MODE_P0;
      @(negedge clk);
      start_test(pend_tag);
      check_gnt(gnt, pend_exp);
    end
    finish_test();
    if (fd != 0) begin
      $fclose(fd);
    end

    $display("Tests passed: %0d, tests failed: %0d, wrong grants: %0d",
             tests_passed, tests_failed, total_errs);
    if (aborted || total_errs != 0) begin
      $display("TEST RESULT: FAIL");
    end else begin
      $display("TEST RESULT: PASS");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/arb4_top.sv
// ----------------------------------------------------------------------
// Four-requester arbiter top built from mode decode, grant select and
// grant register. The grant follows req and arb_type by one cycle.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module arb4_top import arb_pkg::*; (
  input  wire                clk,
  input  wire                rst_n,
  input  wire  [NUM_REQ-1:0] req,
  input  wire  [MODE_W-1:0]  arb_type,
  output logic [NUM_REQ-1:0] gnt
);

  logic [IDX_W-1:0]   head;
  logic               rotate;
  logic               mode_ok;
  logic [NUM_REQ-1:0] next_gnt;
  logic [IDX_W-1:0]   last_idx;

  arb_mode_decode arb_mode_decode_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .arb_type (arb_type),
    .last_idx (last_idx),
    .head     (head),
    .rotate   (rotate),
    .mode_ok  (mode_ok)
  );

  grant_select grant_select_inst (
    .req      (req),
    .head     (head),
    .rotate   (rotate),
    .next_gnt (next_gnt)
  );

  grant_register grant_register_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .next_gnt (next_gnt),
    .mode_ok  (mode_ok),
    .gnt      (gnt),
    .last_idx (last_idx)
  );

  // No grant without a request on the sampling edge
  a_gnt_was_requested: assert property (
    @(posedge clk) disable iff (!rst_n)
    (gnt & ~$past(req)) == '0
  );

endmodule

`default_nettype wire

// File: source/arb_mode_decode.sv
// ----------------------------------------------------------------------
// Mode decode that turns the arbitration mode into a priority head,
// an ordering style and a legal-mode flag for the grant path.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module arb_mode_decode import arb_pkg::*; (
  input  wire               clk,
  input  wire               rst_n,
  input  wire  [MODE_W-1:0] arb_type,
  input  wire  [IDX_W-1:0]  last_idx,
  output logic [IDX_W-1:0]  head,
  output logic              rotate,
  output logic              mode_ok
);

  logic [IDX_W-1:0] rand_n;

  // Random head source and the only clocked state here
  pn_seq_gen pn_seq_gen_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .rand_n (rand_n)
  );

  always_comb begin
    head    = '0;
    mode_ok = 1'b1;
    case (arb_type)
      MODE_P0,
      MODE_P1,
      MODE_P2,
      MODE_P3: begin
        head = arb_type[IDX_W-1:0]; // Mode number is the head
      end
      MODE_RR: begin
        head = last_idx + IDX_W'(1); // Wraps modulo 4
      end
      MODE_RAND: begin
        head = rand_n;
      end
      default: begin
        mode_ok = 1'b0;
      end
    endcase
  end

  // Only round robin walks the ring from the head
  assign rotate = (arb_type == MODE_RR);

endmodule

`default_nettype wire

// File: source/arb_pkg.sv
// ----------------------------------------------------------------------
// Shared sizes and mode encodings for the four-requester arbiter.
// Imported by every RTL block and by the testbench.
// ----------------------------------------------------------------------
`default_nettype none

package arb_pkg;

  localparam int NUM_REQ = 4;
  localparam int IDX_W   = 2;
  localparam int MODE_W  = 3;

  // Fixed priority with the named requester first
  localparam logic [MODE_W-1:0] MODE_P0 = 3'd0;
  localparam logic [MODE_W-1:0] MODE_P1 = 3'd1;
  localparam logic [MODE_W-1:0] MODE_P2 = 3'd2;
  localparam logic [MODE_W-1:0] MODE_P3 = 3'd3;

  localparam logic [MODE_W-1:0] MODE_RR   = 3'd4; // Round robin
  localparam logic [MODE_W-1:0] MODE_RAND = 3'd5; // LFSR picks the head

  // First round-robin head after reset is requester 0
  localparam logic [IDX_W-1:0] LAST_IDX_RESET = 2'd3;

endpackage

`default_nettype wire

// File: source/grant_register.sv
// ----------------------------------------------------------------------
// Output stage that registers the grant, masks illegal modes and keeps
// the last winner's index for the round-robin head.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module grant_register import arb_pkg::*; (
  input  wire                clk,
  input  wire                rst_n,
  input  wire  [NUM_REQ-1:0] next_gnt,
  input  wire                mode_ok,
  output logic [NUM_REQ-1:0] gnt,
  output logic [IDX_W-1:0]   last_idx
);

  logic [NUM_REQ-1:0] gnt_d;
  logic [IDX_W-1:0]   gnt_idx;

  assign gnt_d = mode_ok ? next_gnt : '0; // Illegal mode grants nobody

  // One-hot to index
  always_comb begin
    gnt_idx = '0;
    for (int i = 0; i < NUM_REQ; i++) begin
      if (gnt_d[i]) begin
        gnt_idx = IDX_W'(i);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt      <= '0;
      last_idx <= LAST_IDX_RESET;
    end else begin
      gnt <= gnt_d;
      // Idle and illegal cycles keep the previous winner
      if (|gnt_d) begin
        last_idx <= gnt_idx;
      end
    end
  end

  a_gnt_onehot0: assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(gnt)
  );

  // Illegal mode blanks the following grant
  a_illegal_no_gnt: assert property (
    @(posedge clk) disable iff (!rst_n)
    !mode_ok |=> (gnt == '0)
  );

endmodule

`default_nettype wire

// File: source/grant_select.sv
// ----------------------------------------------------------------------
// Grant selection that builds the search order from head and ordering
// style and picks the first asserting requester. Combinational.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module grant_select import arb_pkg::*; (
  input  wire  [NUM_REQ-1:0] req,
  input  wire  [IDX_W-1:0]   head,
  input  wire                rotate,
  output logic [NUM_REQ-1:0] next_gnt
);

  logic [IDX_W-1:0] order [NUM_REQ];

  // Slot 0 is always the head
  always_comb begin
    order[0] = head;
    for (int k = 1; k < NUM_REQ; k++) begin
      if (rotate) begin
        order[k] = head + IDX_W'(k); // head+k modulo 4
      end else if (IDX_W'(k - 1) < head) begin
        order[k] = IDX_W'(k - 1);    // Ascending below the head
      end else begin
        order[k] = IDX_W'(k);        // Skip over the head
      end
    end
  end

  // First hit in search order wins
  always_comb begin
    logic found;
    found    = 1'b0;
    next_gnt = '0;
    for (int k = 0; k < NUM_REQ; k++) begin
      if (!found && req[order[k]]) begin
        next_gnt[order[k]] = 1'b1;
        found              = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/pn_seq_gen.sv
// ----------------------------------------------------------------------
// 3-bit maximal-length LFSR giving a 2-bit pseudo-random head index.
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pn_seq_gen import arb_pkg::*; (
  input  wire              clk,
  input  wire              rst_n,
  output logic [IDX_W-1:0] rand_n
);

  logic s1;
  logic s2;
  logic s3;
  logic s1_next;

  assign s1_next = s1 ^ s3; // Feedback tap

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1 <= 1'b1;
      s2 <= 1'b0;
      s3 <= 1'b0;
    end else begin
      s1 <= s1_next;
      s2 <= s1;
      s3 <= s2;
    end
  end

  assign rand_n = {s3, s2};

  // Lock-up state would freeze the random head
  a_state_not_zero: assert property (
    @(posedge clk) disable iff (!rst_n)
    {s1, s2, s3} != 3'b000
  );

endmodule

`default_nettype wire
